//--- Makefile
# Verilator flow for the PI1 to Wishbone B4 bridge

TOP = pi1_wb4_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

# Pass or fail comes from the log, not the simulator exit code
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
source/pi1_wb4_pkg.sv
source/pi1_bridge_fsm.sv
source/pi1_bridge_datapath.sv
source/wb4_ack_timer.sv
source/wb4_ram.sv
source/pi1_wb4_top.sv
testbench/pi1_wb4_tb.sv

//--- source/pi1_bridge_datapath.sv
// ----------------------------------------------------------------------
// Bus address points at the lowest enabled byte lane, lane 0 if none
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module pi1_bridge_datapath import pi1_wb4_pkg::*; #(
	parameter int DATA_W = ARCH_W
) (
	input  wire logic                 clk_i,
	input  wire logic                 rst_i,
	input  pi1_req_t                  pi1_req_i,
	input  wire logic                 accept_i,
	input  wire logic                 swap_ack_i,
	input  wire logic                 ack_i,
	input  wire logic [DATA_W-1:0]    rd_data_i,
	output logic                      swap_o,
	output logic [DATA_W-1:0]         wb_adr_o,
	output logic [DATA_W-1:0]         wb_dat_o,
	output logic [DATA_W/8-1:0]       wb_sel_o,
	output logic [DATA_W-1:0]         pi1_data_o
);

	localparam int SEL_N = DATA_W / 8;
	localparam int LANE_W = $clog2(SEL_N);

	logic [LANE_W-1:0] lane;
	logic [DATA_W-1:0] old_q;
	pi1_op_e           op_q;
	logic              final_ack;

	// Priority pick, lowest lane wins
	always_comb begin
		lane = '0;
		for (int i = SEL_N - 1; i >= 0; i--) begin
			if (pi1_req_i.sel[i]) begin
				lane = LANE_W'(i);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept_i) begin
			wb_adr_o <= {pi1_req_i.adr[DATA_W-LANE_W-1:0], lane};
			wb_dat_o <= pi1_req_i.dat[DATA_W-1:0];
			wb_sel_o <= pi1_req_i.sel[SEL_N-1:0];
		end
		if (swap_ack_i) begin
			old_q <= rd_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			op_q <= PI1_NOOP;
		end else if (accept_i) begin
			op_q <= pi1_req_i.op;
		end
	end

	assign swap_o = (op_q == PI1_SWAP);
	assign final_ack = ack_i && !swap_ack_i;

	// Data only shows in the completion cycle of a read or swap
	always_comb begin
		pi1_data_o = '0;
		if (final_ack) begin
			if (op_q == PI1_READ) begin
				pi1_data_o = rd_data_i;
			end else if (op_q == PI1_SWAP) begin
				pi1_data_o = old_q;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pi1_bridge_fsm.sv
// ----------------------------------------------------------------------
// One transfer in flight; a swap runs as a read then a write in one cyc
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module pi1_bridge_fsm import pi1_wb4_pkg::*; (
	input  wire logic     clk_i,
	input  wire logic     rst_i,
	input  pi1_op_e       pi1_op_i,
	input  wb4_rsp_t      wb_rsp_i,
	output logic          pi1_rdy_o,
	output logic          accept_o,
	output logic          swap_ack_o,
	output logic          cyc_o,
	output logic          stb_o,
	output logic          we_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_SWAP_RD,
		ST_SWAP_WR
	} state_e;

	state_e state_q;
	logic   live_q;

	// Ready is held low until the first clock after reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			live_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
		end
	end

	// Free when idle, or when the last ack of the operation arrives
	assign pi1_rdy_o = live_q &&
		(state_q == ST_IDLE || (wb_rsp_i.ack && state_q != ST_SWAP_RD));
	assign accept_o = pi1_rdy_o && (pi1_op_i != PI1_NOOP);
	assign swap_ack_o = (state_q == ST_SWAP_RD) && wb_rsp_i.ack;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			cyc_o   <= 1'b0;
			stb_o   <= 1'b0;
			we_o    <= 1'b0;
		end else if (pi1_rdy_o) begin
			if (accept_o) begin
				cyc_o   <= 1'b1;
				stb_o   <= 1'b1;
				we_o    <= (pi1_op_i == PI1_WRITE);
				state_q <= (pi1_op_i == PI1_SWAP) ? ST_SWAP_RD : ST_ACCESS;
			end else begin
				cyc_o   <= 1'b0;
				stb_o   <= 1'b0;
				we_o    <= 1'b0;
				state_q <= ST_IDLE;
			end
		end else if (swap_ack_o) begin
			// Read half done, strobe again for the write half
			stb_o   <= 1'b1;
			we_o    <= 1'b1;
			state_q <= ST_SWAP_WR;
		end else if (stb_o && !wb_rsp_i.stall) begin
			stb_o <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Bus protocol checks

	a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_o |-> cyc_o)
		else $error("stb high outside a cycle");

	a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_rsp_i.ack |-> cyc_o)
		else $error("ack seen with cyc low");

	a_stb_held: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_o && wb_rsp_i.stall |=> stb_o)
		else $error("stb dropped while stalled");

endmodule

`default_nettype wire

//--- source/pi1_wb4_pkg.sv
// ----------------------------------------------------------------------
// Struct fields are sized by ARCH_W; every module's DATA_W must match it
// ----------------------------------------------------------------------

`default_nettype none

package pi1_wb4_pkg;

	// Default bus width, change here to build a 16 or 64 bit system
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;
	localparam int BYTE_IDX_W = $clog2(SEL_W);
	localparam int WADR_W = ARCH_W - BYTE_IDX_W;

	// PI1 operation codes
	typedef enum logic [1:0] {
		PI1_NOOP  = 2'b00,
		PI1_WRITE = 2'b01,
		PI1_READ  = 2'b10,
		PI1_SWAP  = 2'b11
	} pi1_op_e;

	// ------------------------------------------------------------------
	// Processor side request, held by the master until accepted
	typedef struct packed {
		pi1_op_e             op;
		logic [WADR_W-1:0]   adr;
		logic [ARCH_W-1:0]   dat;
		logic [SEL_W-1:0]    sel;
	} pi1_req_t;

	// ------------------------------------------------------------------
	// Wishbone B4 pipelined, master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [ARCH_W-1:0]   adr;
		logic [ARCH_W-1:0]   dat;
		logic [SEL_W-1:0]    sel;
	} wb4_req_t;

	// Slave to master
	typedef struct packed {
		logic                stall;
		logic                ack;
		logic [ARCH_W-1:0]   dat;
	} wb4_rsp_t;

endpackage

`default_nettype wire

//--- source/pi1_wb4_top.sv
// ----------------------------------------------------------------------
// DATA_W must equal the package ARCH_W; bus is exposed for observation
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module pi1_wb4_top import pi1_wb4_pkg::*; #(
	parameter int DATA_W = ARCH_W,
	parameter int MEM_WORDS = 64,
	parameter int WAIT_CYCLES = 1
) (
	input  wire logic          clk_i,
	input  wire logic          rst_i,
	input  pi1_req_t           pi1_req_i,
	output logic               pi1_rdy_o,
	output logic [DATA_W-1:0]  pi1_data_o,
	output wb4_req_t           wb_req_o,
	output wb4_rsp_t           wb_rsp_o
);

	logic accept, swap_ack, swap;

	if (DATA_W != ARCH_W) begin : g_width_check
		$error("DATA_W must equal ARCH_W from pi1_wb4_pkg");
	end

	pi1_bridge_fsm pi1_bridge_fsm_inst (
		.clk_i, .rst_i,
		.pi1_op_i  (pi1_req_i.op),
		.wb_rsp_i  (wb_rsp_o),
		.pi1_rdy_o,
		.accept_o  (accept),
		.swap_ack_o(swap_ack),
		.cyc_o     (wb_req_o.cyc),
		.stb_o     (wb_req_o.stb),
		.we_o      (wb_req_o.we)
	);

	pi1_bridge_datapath #(.DATA_W(DATA_W)) pi1_bridge_datapath_inst (
		.clk_i, .rst_i, .pi1_req_i,
		.accept_i  (accept),
		.swap_ack_i(swap_ack),
		.ack_i     (wb_rsp_o.ack),
		.rd_data_i (wb_rsp_o.dat[DATA_W-1:0]),
		.swap_o    (swap),
		.wb_adr_o  (wb_req_o.adr[DATA_W-1:0]),
		.wb_dat_o  (wb_req_o.dat[DATA_W-1:0]),
		.wb_sel_o  (wb_req_o.sel[DATA_W/8-1:0]),
		.pi1_data_o
	);

	wb4_ram #(
		.DATA_W(DATA_W), .MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)
	) wb4_ram_inst (.clk_i, .rst_i, .wb_req_i(wb_req_o), .wb_rsp_o);

	// FSM swap phase and datapath op must agree
	a_swap_ack_op: assert property (@(posedge clk_i) disable iff (rst_i)
		swap_ack |-> swap)
		else $error("swap read ack without a swap in the datapath");

endmodule

`default_nettype wire

//--- source/wb4_ack_timer.sv
// ----------------------------------------------------------------------
// Ack comes WAIT_CYCLES+1 clocks after a strobe is taken, one at a time
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module wb4_ack_timer import pi1_wb4_pkg::*; #(
	parameter int WAIT_CYCLES = 1
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	input  wire logic stb_i,
	output logic      stall_o,
	output logic      ack_o
);

	localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic             busy_q;
	logic [CNT_W-1:0] cnt_q;
	logic             stb_take;

	// A strobe may also be taken in the ack cycle
	assign stall_o = busy_q && (cnt_q != '0);
	assign ack_o = busy_q && (cnt_q == '0);
	assign stb_take = stb_i && !stall_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (stb_take) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_W'(WAIT_CYCLES);
		end else if (ack_o) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	a_ack_after_take: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> $past(stb_take, WAIT_CYCLES + 1))
		else $error("ack without an accepted strobe");

endmodule

`default_nettype wire

//--- source/wb4_ram.sv
// ----------------------------------------------------------------------
// Word address wraps modulo MEM_WORDS; contents are not reset
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module wb4_ram import pi1_wb4_pkg::*; #(
	parameter int DATA_W = ARCH_W,
	parameter int MEM_WORDS = 64,
	parameter int WAIT_CYCLES = 1
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	input  wb4_req_t  wb_req_i,
	output wb4_rsp_t  wb_rsp_o
);

	localparam int SEL_N = DATA_W / 8;
	localparam int LANE_W = $clog2(SEL_N);
	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [IDX_W-1:0]  idx_q;
	logic [DATA_W-1:0] dat_q;
	logic [SEL_N-1:0]  sel_q;
	logic              we_q;
	logic              stall;
	logic              ack;

	wb4_ack_timer #(
		.WAIT_CYCLES(WAIT_CYCLES)
	) wb4_ack_timer_inst (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.stb_i  (wb_req_i.cyc && wb_req_i.stb),
		.stall_o(stall),
		.ack_o  (ack)
	);

	// Latch the transfer when its strobe is taken, write it on the ack
	always_ff @(posedge clk_i) begin
		if (wb_req_i.cyc && wb_req_i.stb && !stall) begin
			idx_q <= IDX_W'(wb_req_i.adr[DATA_W-1:LANE_W] % MEM_WORDS);
			dat_q <= wb_req_i.dat[DATA_W-1:0];
			sel_q <= wb_req_i.sel[SEL_N-1:0];
			we_q  <= wb_req_i.we;
		end
		if (ack && we_q) begin
			for (int b = 0; b < SEL_N; b++) begin
				if (sel_q[b]) begin
					mem[idx_q][8*b +: 8] <= dat_q[8*b +: 8];
				end
			end
		end
	end

	always_comb begin
		wb_rsp_o = '0;
		wb_rsp_o.stall = stall;
		wb_rsp_o.ack = ack;
		if (ack && !we_q) begin
			wb_rsp_o.dat[DATA_W-1:0] = mem[idx_q];
		end
	end

endmodule

`default_nettype wire

//--- testbench/pi1_wb4_tb.sv
// ----------------------------------------------------------------------
// Directed tests against a reference memory; built for 64 words, 2 waits
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module pi1_wb4_tb import pi1_wb4_pkg::*;;

	localparam int MEM_WORDS = 64;
	localparam int WAIT_CYCLES = 2;
	localparam int TIMEOUT_CYCLES = 4000;

	logic                clk_i = 1'b0;
	logic                rst_i;
	pi1_req_t            pi1_req_i;
	logic                pi1_rdy_o;
	logic [ARCH_W-1:0]   pi1_data_o;
	wb4_req_t            wb_req_o;
	wb4_rsp_t            wb_rsp_o;

	logic [ARCH_W-1:0]   model [MEM_WORDS];
	logic [ARCH_W-1:0]   rdata;
	string               cur_test;
	int                  errors = 0;
	int                  tests_run = 0;
	int unsigned         cycles = 0;

	pi1_wb4_top #(
		.DATA_W(ARCH_W), .MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)
	) pi1_wb4_top_inst (
		.clk_i, .rst_i, .pi1_req_i, .pi1_rdy_o, .pi1_data_o, .wb_req_o, .wb_rsp_o
	);

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles, a transfer never finished", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Reference helpers

	function automatic logic [1:0] lowest_lane(input logic [SEL_W-1:0] sel);
		logic [1:0] lane;
		lane = 2'd0;
		for (int i = SEL_W - 1; i >= 0; i--) begin
			if (sel[i]) begin
				lane = 2'(i);
			end
		end
		return lane;
	endfunction

	function automatic logic [ARCH_W-1:0] merge_bytes(input logic [ARCH_W-1:0] old_w,
		input logic [ARCH_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] res;
		res = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errors++;
		$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR in %s: %s", cur_test, what);
	endtask

	task automatic finish_test(input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d errors", cur_test, errors - errs_before);
		end
	endtask

	// ------------------------------------------------------------------
	// Issue one PI1 operation, watch the bus, check against the model
	// Entered and left on a falling edge

	task automatic issue_op(input pi1_op_e op, input logic [WADR_W-1:0] adr,
		input logic [ARCH_W-1:0] dat, input logic [SEL_W-1:0] sel,
		output logic [ARCH_W-1:0] data_out);
		logic [5:0]        idx;
		logic [ARCH_W-1:0] exp_data;
		logic [ARCH_W-1:0] exp_adr;
		logic [1:0]        we_seq;
		logic [1:0]        exp_we;
		int                exp_stb;
		int                exp_cyc;
		int                n_stb;
		int                n_ack;
		int                n_stall;
		int                n_cyc;
		logic              done;
		idx = adr[5:0];
		exp_adr = {adr, lowest_lane(sel)};
		exp_data = (op == PI1_READ || op == PI1_SWAP) ? model[idx] : '0;
		exp_stb = (op == PI1_NOOP) ? 0 : ((op == PI1_SWAP) ? 2 : 1);
		exp_we = (op == PI1_WRITE || op == PI1_SWAP) ? 2'b01 : 2'b00;
		exp_cyc = (op == PI1_NOOP) ? 1 : exp_stb * (WAIT_CYCLES + 2);
		we_seq = 2'b00;
		n_stb = 0;
		n_ack = 0;
		n_stall = 0;
		n_cyc = 0;
		done = 1'b0;
		pi1_req_i.op = op;
		pi1_req_i.adr = adr;
		pi1_req_i.dat = dat;
		pi1_req_i.sel = sel;
		while (pi1_rdy_o !== 1'b1) begin
			@(negedge clk_i);
		end
		@(negedge clk_i);
		pi1_req_i.op = PI1_NOOP;
		while (!done) begin
			n_cyc++;
			if (op != PI1_NOOP && wb_req_o.cyc !== 1'b1) begin
				report_problem("cyc low before the final ack");
			end
			if (wb_req_o.stb && !wb_rsp_o.stall) begin
				n_stb++;
				we_seq = {we_seq[0], wb_req_o.we};
				if (wb_req_o.adr !== exp_adr) begin
					report_mismatch("bus address", exp_adr, wb_req_o.adr);
				end
				if (wb_req_o.sel !== sel) begin
					report_mismatch("bus select", 32'(sel), 32'(wb_req_o.sel));
				end
				if (wb_req_o.we && wb_req_o.dat !== dat) begin
					report_mismatch("bus write data", dat, wb_req_o.dat);
				end
			end
			if (wb_rsp_o.stall) begin
				n_stall++;
			end
			if (wb_rsp_o.ack) begin
				n_ack++;
			end
			if (pi1_rdy_o === 1'b1) begin
				done = 1'b1;
			end else begin
				if (pi1_data_o !== '0) begin
					report_mismatch("data before completion", '0, pi1_data_o);
				end
				@(negedge clk_i);
			end
		end
		data_out = pi1_data_o;
		if (data_out !== exp_data) begin
			report_mismatch("returned data", exp_data, data_out);
		end
		if (n_stb != exp_stb) begin
			report_mismatch("strobe count", exp_stb, n_stb);
		end
		if (n_ack != exp_stb) begin
			report_mismatch("ack count", exp_stb, n_ack);
		end
		if (n_stall != exp_stb * WAIT_CYCLES) begin
			report_mismatch("stall cycles", exp_stb * WAIT_CYCLES, n_stall);
		end
		if (n_cyc != exp_cyc) begin
			report_mismatch("cycles to ready", exp_cyc, n_cyc);
		end
		if (we_seq !== exp_we) begin
			report_mismatch("we order", 32'(exp_we), 32'(we_seq));
		end
		if (op == PI1_WRITE || op == PI1_SWAP) begin
			model[idx] = merge_bytes(model[idx], dat, sel);
		end
	endtask

	// ------------------------------------------------------------------
	// Tests

	task automatic test_reset();
		int errs0;
		errs0 = errors;
		cur_test = "reset";
		rst_i = 1'b1;
		repeat (2) begin
			@(negedge clk_i);
			if (wb_req_o.cyc !== 1'b0 || wb_req_o.stb !== 1'b0 || wb_rsp_o.ack !== 1'b0) begin
				report_problem("bus active while reset is held");
			end
			if (pi1_rdy_o !== 1'b0) begin
				report_problem("ready high while reset is held");
			end
		end
		rst_i = 1'b0;
		@(negedge clk_i);
		if (pi1_rdy_o !== 1'b1) begin
			report_mismatch("ready", 32'd1, 32'(pi1_rdy_o));
		end
		if (pi1_data_o !== '0) begin
			report_mismatch("pi1 data", '0, pi1_data_o);
		end
		if (wb_req_o.cyc !== 1'b0 || wb_req_o.stb !== 1'b0 || wb_rsp_o.ack !== 1'b0) begin
			report_problem("bus active after reset");
		end
		finish_test(errs0);
	endtask

	task automatic test_fill();
		int errs0;
		errs0 = errors;
		cur_test = "fill";
		for (int i = 0; i < MEM_WORDS; i++) begin
			issue_op(PI1_WRITE, WADR_W'(i), 32'h9e3779b9 * (i + 1) ^ 32'h0f0f5a5a,
				4'hf, rdata);
		end
		finish_test(errs0);
	endtask

	task automatic test_word_rw();
		int errs0;
		errs0 = errors;
		cur_test = "word_rw";
		issue_op(PI1_WRITE, 30'h5, 32'hcafe1234, 4'hf, rdata);
		issue_op(PI1_READ, 30'h5, 32'h0, 4'hf, rdata);
		if (rdata !== 32'hcafe1234) begin
			report_mismatch("read back", 32'hcafe1234, rdata);
		end
		finish_test(errs0);
	endtask

	task automatic test_byte_lanes();
		int errs0;
		errs0 = errors;
		cur_test = "byte_lanes";
		issue_op(PI1_WRITE, 30'h12, 32'h11223344, 4'b0100, rdata);
		issue_op(PI1_READ, 30'h12, 32'h0, 4'b0100, rdata);
		issue_op(PI1_WRITE, 30'h13, 32'haabbccdd, 4'b1010, rdata);
		issue_op(PI1_READ, 30'h13, 32'h0, 4'b1000, rdata);
		issue_op(PI1_WRITE, 30'h14, 32'h55667788, 4'b0000, rdata);
		issue_op(PI1_READ, 30'h14, 32'h0, 4'b0001, rdata);
		finish_test(errs0);
	endtask

	task automatic test_swap();
		int                errs0;
		logic [ARCH_W-1:0] old_w;
		errs0 = errors;
		cur_test = "swap";
		old_w = model[7];
		issue_op(PI1_SWAP, 30'h7, 32'h0badf00d, 4'b0011, rdata);
		if (rdata !== old_w) begin
			report_mismatch("old word", old_w, rdata);
		end
		issue_op(PI1_READ, 30'h7, 32'h0, 4'hf, rdata);
		issue_op(PI1_SWAP, 30'h47, 32'h12345678, 4'hf, rdata);
		finish_test(errs0);
	endtask

	task automatic test_noop_stall();
		int errs0;
		errs0 = errors;
		cur_test = "noop_stall";
		issue_op(PI1_NOOP, 30'h21, 32'hffffffff, 4'hf, rdata);
		if (wb_req_o.cyc !== 1'b0) begin
			report_problem("no-op opened a bus cycle");
		end
		issue_op(PI1_READ, 30'h21, 32'h0, 4'hf, rdata);
		issue_op(PI1_WRITE, 30'h3f, 32'hdeadbeef, 4'b1000, rdata);
		issue_op(PI1_NOOP, 30'h3f, 32'h0, 4'h0, rdata);
		finish_test(errs0);
	endtask

	task automatic test_random_mix();
		int                errs0;
		logic [1:0]        op_bits;
		logic [WADR_W-1:0] adr;
		logic [ARCH_W-1:0] dat;
		logic [SEL_W-1:0]  sel;
		errs0 = errors;
		cur_test = "random_mix";
		for (int n = 0; n < 60; n++) begin
			op_bits = 2'($urandom);
			adr = WADR_W'($urandom);
			dat = $urandom;
			sel = 4'($urandom);
			issue_op(pi1_op_e'(op_bits), adr, dat, sel, rdata);
		end
		finish_test(errs0);
	endtask

	initial begin
		void'($urandom(32'hbfabc714));
		pi1_req_i = '0;
		rst_i = 1'b1;
		test_reset();
		test_fill();
		test_word_rw();
		test_byte_lanes();
		test_swap();
		test_noop_stall();
		test_random_mix();
		$display("tests %0d, errors %0d, cycles %0d", tests_run, errors, cycles);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
